// ==== all.f ====
+incdir+.
msx_cart_pkg.sv
wb_if.sv
bus_capture.sv
cycle_bridge.sv
sd_regs.sv
sector_buffer.sv
msx_cart_top.sv
tb_msx_cart.sv

// ==== bus_capture.sv ====
`timescale 1ns/100ps
`include "msx_cart_macros.svh"

module bus_capture
    import msx_cart_pkg::*;
(
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    input  msx_data_t  mp,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       sltsl_n,
    output logic [2:0] msel_n,
    output msx_addr_t  host_addr,
    output bus_ctrl_t  host_ctrl,
    output logic       capture_done,
    output logic       rd_active,
    output logic       wr_active,
    output logic       slot_active
);

    logic [2:0] phase;      // 0..6, one full mux round
    msx_data_t  addr_lo;
    msx_data_t  addr_hi;
    logic [1:0] rd_sync;
    logic [1:0] wr_sync;
    logic [1:0] slt_sync;

    //////////////////// mux sequencer
    // select goes out on even phases, the group is sampled one cycle later
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase        <= 3'd0;
            msel_n       <= `MSEL_NONE;
            capture_done <= 1'b0;
            host_ctrl    <= '1;     // nothing asserted
        end else begin
            capture_done <= 1'b0;
            case (phase)
                3'd0: msel_n <= `MSEL_ADDR_LO;
                3'd2: msel_n <= `MSEL_ADDR_HI;
                3'd4: msel_n <= `MSEL_CTRL;
                3'd5: begin
                    host_ctrl.merq_n <= mp[0];
                    host_ctrl.iorq_n <= mp[1];
                    host_ctrl.m1_n   <= mp[7];
                    capture_done     <= 1'b1;   // seen during phase 6
                end
                3'd6: msel_n <= `MSEL_NONE;
                default: ;
            endcase

            if (phase == 3'd6)
                phase <= 3'd0;
            else
                phase <= phase + 3'd1;
        end
    end

    // address bytes, published together with the control group
    always_ff @(posedge clk108_w) begin
        if (phase == 3'd1)
            addr_lo <= mp;
        if (phase == 3'd3)
            addr_hi <= mp;
        if (phase == 3'd5)
            host_addr <= {addr_hi, addr_lo};
    end

    //////////////////// direct strobes
    // two flops each, pins are async to clk108
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            rd_sync  <= 2'b11;
            wr_sync  <= 2'b11;
            slt_sync <= 2'b11;
        end else begin
            rd_sync  <= {rd_sync[0], rd_n};
            wr_sync  <= {wr_sync[0], wr_n};
            slt_sync <= {slt_sync[0], sltsl_n};
        end
    end

    assign rd_active   = ~rd_sync[1];
    assign wr_active   = ~wr_sync[1];
    assign slot_active = ~slt_sync[1];

endmodule

// ==== cycle_bridge.sv ====
`timescale 1ns/100ps
`include "msx_cart_macros.svh"

module cycle_bridge
    import msx_cart_pkg::*;
(
    input  logic      clk108_w,
    input  logic      ram_enabled_w,
    input  msx_addr_t host_addr,
    input  bus_ctrl_t host_ctrl,
    input  logic      capture_done,
    input  logic      rd_active,
    input  logic      wr_active,
    input  logic      slot_active,
    input  msx_data_t cd_in,
    wb_if.master      wb_buf,
    wb_if.master      wb_reg,
    output msx_data_t cd_out,
    output logic      datadir
);

    logic      mem_access;
    logic      in_window;
    logic      in_sector;
    logic      start;
    logic      served;      // one cycle per host strobe
    logic      busy;
    logic      sel_buf;     // 1 sector area, 0 register page
    logic      we_q;
    wb_adr_t   adr_q;
    msx_data_t dat_q;
    logic      ack;
    msx_data_t rdata;

    // plain memory access in our slot, no io and no opcode fetch
    assign mem_access = (rd_active | wr_active) & slot_active & ~host_ctrl.merq_n
                      & host_ctrl.iorq_n & host_ctrl.m1_n;
    assign in_window = (host_addr >= `SDC_SDATA) && (host_addr <= `SDC_END);
    assign in_sector = host_addr < `SDC_ENABLE;
    assign start     = capture_done & mem_access & ~served & ~busy;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            busy    <= 1'b0;
            served  <= 1'b0;
            sel_buf <= 1'b0;
            cd_out  <= 8'hFF;
        end else begin
            if (!rd_active && !wr_active)
                served <= 1'b0;     // host released both strobes
            else if (start)
                served <= 1'b1;

            if (start && in_window) begin
                busy    <= 1'b1;
                sel_buf <= in_sector;
            end else if (busy && ack) begin
                busy <= 1'b0;       // cyc drops the cycle after ack
                if (!we_q)
                    cd_out <= rdata;
            end

            if (start && !in_window && rd_active)
                cd_out <= 8'hFF;    // slot read outside the window
        end
    end

    always_ff @(posedge clk108_w) begin
        if (start) begin
            we_q  <= wr_active;
            adr_q <= host_addr[`SECTOR_AW-1:0];
            dat_q <= cd_in;
        end
    end

    //////////////////// wishbone masters
    assign wb_buf.cyc   = busy & sel_buf;
    assign wb_buf.stb   = busy & sel_buf;
    assign wb_buf.we    = we_q;
    assign wb_buf.adr   = adr_q;
    assign wb_buf.dat_w = dat_q;

    assign wb_reg.cyc   = busy & ~sel_buf;
    assign wb_reg.stb   = busy & ~sel_buf;
    assign wb_reg.we    = we_q;
    assign wb_reg.adr   = adr_q;
    assign wb_reg.dat_w = dat_q;

    assign ack   = sel_buf ? wb_buf.ack : wb_reg.ack;
    assign rdata = sel_buf ? wb_buf.dat_r : wb_reg.dat_r;

    // drive cd for any read in the slot
    assign datadir = ~(rd_active & slot_active);

endmodule

// ==== msx_cart_macros.svh ====
`ifndef MSX_CART_MACROS_SVH
`define MSX_CART_MACROS_SVH

//////////////////// sd window map
`define SDC_SDATA       16'h7C00    // 7C00h-7DFFh sector transfer area
`define SDC_ENABLE      16'h7E00    // bit 0 opens the register page
`define SDC_CMD         16'h7E01    // 1 read, 2 write, 80h init
`define SDC_STATUS      16'h7E02
`define SDC_SADDR       16'h7E03    // 4 bytes, little endian
`define SDC_C_SIZE      16'h7E07    // 3 bytes of block count
`define SDC_CTYPE       16'h7E0A
`define SDC_END         16'h7EFF

//////////////////// pin mux select codes
// active low, one group enabled at a time
`define MSEL_ADDR_LO    3'b110      // a0-a7
`define MSEL_ADDR_HI    3'b101      // a8-a15
`define MSEL_CTRL       3'b011      // merq, iorq, m1 and friends
`define MSEL_NONE       3'b111

// sector buffer geometry
`define SECTOR_BYTES    512
`define SECTOR_AW       9

`endif

// ==== msx_cart_pkg.sv ====
`include "msx_cart_macros.svh"

package msx_cart_pkg;

    //////////////////// host bus
    typedef logic [15:0] msx_addr_t;    // cartridge address
    typedef logic [7:0]  msx_data_t;    // one bus byte

    // control group as seen on the mux, all active low
    typedef struct packed {
        logic merq_n;
        logic iorq_n;
        logic m1_n;
    } bus_ctrl_t;

    //////////////////// card side
    typedef logic [31:0] sector_t;      // lba
    typedef logic [21:0] card_size_t;   // device size in blocks

    // 0 unknown, 1 sdv1, 2 sdv2, 3 sdhc v2
    typedef logic [1:0]  card_type_t;

    // word address inside one target, covers a full sector
    typedef logic [`SECTOR_AW-1:0] wb_adr_t;

endpackage

// ==== msx_cart_top.sv ====
`timescale 1ns/100ps

module msx_cart_top
    import msx_cart_pkg::*;
(
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    input  msx_data_t  mp,
    input  logic       rd_n,
    input  logic       wr_n,
    input  logic       sltsl_n,
    output logic [2:0] msel_n,
    input  msx_data_t  cd_in,
    output msx_data_t  cd_out,
    output logic       datadir,
    input  logic       sd_busy,
    input  logic       sd_done,
    input  logic       sd_crc_error,
    input  logic       sd_timeout_error,
    input  card_type_t sd_card_type,
    input  card_size_t sd_c_size,
    output logic       sd_rstart,
    output logic       sd_wstart,
    output logic       sd_init,
    output sector_t    sd_sector,
    input  logic       sd_outen,
    input  logic [8:0] sd_outaddr,
    input  msx_data_t  sd_outbyte,
    output msx_data_t  sd_inbyte
);

    msx_addr_t host_addr;
    bus_ctrl_t host_ctrl;
    logic      capture_done;
    logic      rd_active;
    logic      wr_active;
    logic      slot_active;
    logic      sd_enabled;

    wb_if wb_buf ();    // bridge to sector area
    wb_if wb_reg ();    // bridge to register page

    bus_capture u_capture (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .msel_n        (msel_n),
        .host_addr     (host_addr),
        .host_ctrl     (host_ctrl),
        .capture_done  (capture_done),
        .rd_active     (rd_active),
        .wr_active     (wr_active),
        .slot_active   (slot_active)
    );

    cycle_bridge u_bridge (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .host_addr     (host_addr),
        .host_ctrl     (host_ctrl),
        .capture_done  (capture_done),
        .rd_active     (rd_active),
        .wr_active     (wr_active),
        .slot_active   (slot_active),
        .cd_in         (cd_in),
        .wb_buf        (wb_buf),
        .wb_reg        (wb_reg),
        .cd_out        (cd_out),
        .datadir       (datadir)
    );

    sd_regs u_regs (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .wb               (wb_reg),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_card_type     (sd_card_type),
        .sd_c_size        (sd_c_size),
        .sd_enabled       (sd_enabled),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_sector        (sd_sector)
    );

    sector_buffer u_buffer (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .wb            (wb_buf),
        .sd_enabled    (sd_enabled),
        .sd_rstart     (sd_rstart),
        .sd_wstart     (sd_wstart),
        .sd_outen      (sd_outen),
        .sd_outaddr    (sd_outaddr),
        .sd_outbyte    (sd_outbyte),
        .sd_inbyte     (sd_inbyte)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_msx_cart -f all.f -o tb_msx_cart
./obj_dir/tb_msx_cart | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== sd_regs.sv ====
`timescale 1ns/100ps
`include "msx_cart_macros.svh"

module sd_regs
    import msx_cart_pkg::*;
(
    input  logic       clk108_w,
    input  logic       ram_enabled_w,
    wb_if.slave        wb,
    input  logic       sd_busy,
    input  logic       sd_done,
    input  logic       sd_crc_error,
    input  logic       sd_timeout_error,
    input  card_type_t sd_card_type,
    input  card_size_t sd_c_size,
    output logic       sd_enabled,
    output logic       sd_rstart,
    output logic       sd_wstart,
    output logic       sd_init,
    output sector_t    sd_sector
);

    // offsets inside the 7E00h page
    localparam wb_adr_t A_ENABLE = wb_adr_t'(`SDC_ENABLE);
    localparam wb_adr_t A_CMD    = wb_adr_t'(`SDC_CMD);
    localparam wb_adr_t A_STATUS = wb_adr_t'(`SDC_STATUS);
    localparam wb_adr_t A_SADDR  = wb_adr_t'(`SDC_SADDR);
    localparam wb_adr_t A_C_SIZE = wb_adr_t'(`SDC_C_SIZE);
    localparam wb_adr_t A_CTYPE  = wb_adr_t'(`SDC_CTYPE);

    logic      req;
    logic      ack_q;
    msx_data_t rd_q;
    msx_data_t rd_mux;

    assign req = wb.cyc & wb.stb & ~ack_q;

    //////////////////// read decode
    always_comb begin
        rd_mux = 8'hFF;
        if (wb.adr == A_ENABLE) begin
            rd_mux = {7'b0, sd_enabled};    // readable even when closed
        end else if (sd_enabled) begin
            case (wb.adr)
                A_STATUS:          rd_mux = {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
                A_C_SIZE:          rd_mux = sd_c_size[7:0];
                A_C_SIZE + 9'd1:   rd_mux = sd_c_size[15:8];
                A_C_SIZE + 9'd2:   rd_mux = {2'b0, sd_c_size[21:16]};
                A_CTYPE:           rd_mux = {6'b0, sd_card_type};
                default:           rd_mux = 8'hFF;
            endcase
        end
    end

    //////////////////// control bits
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ack_q      <= 1'b0;
            sd_enabled <= 1'b0;
            sd_rstart  <= 1'b0;
            sd_wstart  <= 1'b0;
            sd_init    <= 1'b0;
        end else begin
            ack_q <= req;   // answer one cycle after stb

            if (sd_done) begin
                sd_rstart <= 1'b0;
                sd_wstart <= 1'b0;
            end

            if (req && wb.we) begin
                if (wb.adr == A_ENABLE) begin
                    sd_enabled <= wb.dat_w[0];
                end else if (sd_enabled && wb.adr == A_CMD) begin
                    // sticky until the engine reports done
                    sd_rstart <= sd_rstart | wb.dat_w[0];
                    sd_wstart <= sd_wstart | wb.dat_w[1];
                    sd_init   <= sd_init | wb.dat_w[7];
                end
            end
        end
    end

    // sector number and read data
    always_ff @(posedge clk108_w) begin
        if (req && !wb.we)
            rd_q <= rd_mux;
        if (req && wb.we && sd_enabled) begin
            case (wb.adr)
                A_SADDR:          sd_sector[7:0]   <= wb.dat_w;
                A_SADDR + 9'd1:   sd_sector[15:8]  <= wb.dat_w;
                A_SADDR + 9'd2:   sd_sector[23:16] <= wb.dat_w;
                A_SADDR + 9'd3:   sd_sector[31:24] <= wb.dat_w;
                default: ;
            endcase
        end
    end

    assign wb.ack   = ack_q;
    assign wb.dat_r = rd_q;

endmodule

// ==== sector_buffer.sv ====
`timescale 1ns/100ps
`include "msx_cart_macros.svh"

module sector_buffer
    import msx_cart_pkg::*;
(
    input  logic                  clk108_w,
    input  logic                  ram_enabled_w,
    wb_if.slave                   wb,
    input  logic                  sd_enabled,
    input  logic                  sd_rstart,
    input  logic                  sd_wstart,
    input  logic                  sd_outen,
    input  logic [`SECTOR_AW-1:0] sd_outaddr,
    input  msx_data_t             sd_outbyte,
    output msx_data_t             sd_inbyte
);

    msx_data_t mem [`SECTOR_BYTES];
    logic      req;
    logic      ack_q;
    msx_data_t host_q;

    assign req = wb.cyc & wb.stb & ~ack_q;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w)
            ack_q <= 1'b0;
        else
            ack_q <= req;   // acks even while closed
    end

    //////////////////// write ports
    always_ff @(posedge clk108_w) begin
        if (req && wb.we && sd_enabled)
            mem[wb.adr] <= wb.dat_w;
        if (sd_rstart && sd_outen)
            mem[sd_outaddr] <= sd_outbyte;  // card fills during a read command
    end

    // read ports
    always_ff @(posedge clk108_w) begin
        if (req && !wb.we)
            host_q <= sd_enabled ? mem[wb.adr] : 8'hFF;
        if (sd_wstart && sd_outen)
            sd_inbyte <= mem[sd_outaddr];   // one cycle behind outen
    end

    assign wb.ack   = ack_q;
    assign wb.dat_r = host_q;

endmodule

// ==== tb_msx_cart.sv ====
`timescale 1ns/100ps
`include "msx_cart_macros.svh"

module tb_msx_cart
    import msx_cart_pkg::*;
();

    localparam int SETUP_CYCLES   = 14;     // two mux rounds so the address settles
    localparam int HOLD_CYCLES    = 30;
    localparam int SAMPLE_CYCLE   = 28;
    localparam int RELEASE_CYCLES = 10;
    localparam int ACCESS_CYCLES  = SETUP_CYCLES + HOLD_CYCLES + RELEASE_CYCLES;
    localparam int N_ACCESS       = 100;    // upper bound over all tests
    localparam int N_RANDOM       = 48;
    localparam int N_CARD         = 8;

    logic                  clk108_w;
    logic                  ram_enabled_w;
    msx_data_t             mp;
    logic                  rd_n;
    logic                  wr_n;
    logic                  sltsl_n;
    logic [2:0]            msel_n;
    msx_data_t             cd_in;
    msx_data_t             cd_out;
    logic                  datadir;
    logic                  sd_busy;
    logic                  sd_done;
    logic                  sd_crc_error;
    logic                  sd_timeout_error;
    card_type_t            sd_card_type;
    card_size_t            sd_c_size;
    logic                  sd_rstart;
    logic                  sd_wstart;
    logic                  sd_init;
    sector_t               sd_sector;
    logic                  sd_outen;
    logic [`SECTOR_AW-1:0] sd_outaddr;
    msx_data_t             sd_outbyte;
    msx_data_t             sd_inbyte;

    // host side state seen through the pin mux
    msx_addr_t host_a;
    logic      ctl_merq_n;
    logic      ctl_iorq_n;
    logic      ctl_m1_n;

    //////////////////// reference model
    logic      m_enabled;
    msx_data_t m_mem [`SECTOR_BYTES];
    sector_t   m_sector;
    logic      m_rstart;
    logic      m_wstart;
    logic      m_init;
    msx_addr_t known_q [$];     // sector addresses holding known data

    msx_cart_top uut (
        .clk108_w         (clk108_w),
        .ram_enabled_w    (ram_enabled_w),
        .mp               (mp),
        .rd_n             (rd_n),
        .wr_n             (wr_n),
        .sltsl_n          (sltsl_n),
        .msel_n           (msel_n),
        .cd_in            (cd_in),
        .cd_out           (cd_out),
        .datadir          (datadir),
        .sd_busy          (sd_busy),
        .sd_done          (sd_done),
        .sd_crc_error     (sd_crc_error),
        .sd_timeout_error (sd_timeout_error),
        .sd_card_type     (sd_card_type),
        .sd_c_size        (sd_c_size),
        .sd_rstart        (sd_rstart),
        .sd_wstart        (sd_wstart),
        .sd_init          (sd_init),
        .sd_sector        (sd_sector),
        .sd_outen         (sd_outen),
        .sd_outaddr       (sd_outaddr),
        .sd_outbyte       (sd_outbyte),
        .sd_inbyte        (sd_inbyte)
    );

    initial begin
        clk108_w = 1'b0;
        forever #10 clk108_w = ~clk108_w;
    end

    // external mux follows the select lines
    always_comb begin
        case (msel_n)
            `MSEL_ADDR_LO: mp = host_a[7:0];
            `MSEL_ADDR_HI: mp = host_a[15:8];
            `MSEL_CTRL:    mp = {ctl_m1_n, 5'b11111, ctl_iorq_n, ctl_merq_n};
            default:       mp = 8'hFF;
        endcase
    end

    initial begin
        repeat (16 + N_ACCESS * ACCESS_CYCLES + 500) @(posedge clk108_w);
        $display("watchdog expired at %0t ns, the test sequence did not finish", $time);
        abort_run();
    end

    //////////////////// checks
    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input string what, input msx_data_t got, input msx_data_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sector(input string what, input sector_t got, input sector_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_msel(input string what, input logic [2:0] got,
                              input logic [2:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cmd_bits();
        check_bit("sd_rstart", sd_rstart, m_rstart);
        check_bit("sd_wstart", sd_wstart, m_wstart);
        check_bit("sd_init", sd_init, m_init);
    endtask

    // all stimulus changes 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk108_w);
        #2;
    endtask

    //////////////////// host bus model
    task automatic host_access(input msx_addr_t addr, input logic write, input logic in_slot,
                               input msx_data_t wdata, output msx_data_t rdata,
                               output logic dir);
        host_a     = addr;
        ctl_merq_n = 1'b0;
        repeat (SETUP_CYCLES) next_cycle();
        sltsl_n = ~in_slot;
        cd_in   = wdata;
        if (write)
            wr_n = 1'b0;
        else
            rd_n = 1'b0;
        for (int c = 1; c <= HOLD_CYCLES; c++) begin
            next_cycle();
            if (c == SAMPLE_CYCLE) begin
                rdata = cd_out;
                dir   = datadir;
            end
        end
        rd_n       = 1'b1;
        wr_n       = 1'b1;
        sltsl_n    = 1'b1;
        ctl_merq_n = 1'b1;
        repeat (RELEASE_CYCLES) next_cycle();
    endtask

    function automatic msx_data_t expected_read(input msx_addr_t addr);
        if (addr < `SDC_SDATA || addr > `SDC_END)
            return 8'hFF;
        if (addr < `SDC_ENABLE)
            return m_enabled ? m_mem[addr[`SECTOR_AW-1:0]] : 8'hFF;
        if (addr == `SDC_ENABLE)
            return {7'b0, m_enabled};
        if (!m_enabled)
            return 8'hFF;
        case (addr)
            `SDC_STATUS:         return {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
            `SDC_C_SIZE:         return sd_c_size[7:0];
            `SDC_C_SIZE + 16'd1: return sd_c_size[15:8];
            `SDC_C_SIZE + 16'd2: return {2'b0, sd_c_size[21:16]};
            `SDC_CTYPE:          return {6'b0, sd_card_type};
            default:             return 8'hFF;
        endcase
    endfunction

    function automatic void model_write(input msx_addr_t addr, input msx_data_t data);
        if (addr < `SDC_SDATA || addr > `SDC_END)
            return;
        if (addr == `SDC_ENABLE) begin
            m_enabled = data[0];
        end else if (m_enabled) begin
            if (addr < `SDC_ENABLE) begin
                m_mem[addr[`SECTOR_AW-1:0]] = data;
                known_q.push_back(addr);
            end
            case (addr)
                `SDC_CMD: begin
                    m_rstart = m_rstart | data[0];
                    m_wstart = m_wstart | data[1];
                    m_init   = m_init | data[7];
                end
                `SDC_SADDR:         m_sector[7:0]   = data;
                `SDC_SADDR + 16'd1: m_sector[15:8]  = data;
                `SDC_SADDR + 16'd2: m_sector[23:16] = data;
                `SDC_SADDR + 16'd3: m_sector[31:24] = data;
                default: ;
            endcase
        end
    endfunction

    task automatic host_write(input msx_addr_t addr, input msx_data_t data);
        msx_data_t rd;
        logic      dir;
        host_access(addr, 1'b1, 1'b1, data, rd, dir);
        model_write(addr, data);
    endtask

    task automatic host_read_check(input string what, input msx_addr_t addr);
        msx_data_t rd;
        logic      dir;
        host_access(addr, 1'b0, 1'b1, 8'h00, rd, dir);
        check_data(what, rd, expected_read(addr));
        check_bit({what, " datadir"}, dir, 1'b0);
    endtask

    //////////////////// card engine model
    task automatic card_write(input logic [`SECTOR_AW-1:0] off, input msx_data_t data);
        sd_outaddr = off;
        sd_outbyte = data;
        sd_outen   = 1'b1;
        next_cycle();
        sd_outen = 1'b0;
        if (m_rstart) begin
            m_mem[off] = data;
            known_q.push_back(`SDC_SDATA + {7'b0, off});
        end
        next_cycle();
    endtask

    task automatic card_read_check(input logic [`SECTOR_AW-1:0] off);
        sd_outaddr = off;
        sd_outen   = 1'b1;
        next_cycle();
        sd_outen = 1'b0;
        check_data("sd_inbyte", sd_inbyte, m_mem[off]);    // one cycle after outen
        next_cycle();
    endtask

    task automatic done_pulse();
        sd_done = 1'b1;
        next_cycle();
        sd_done  = 1'b0;
        m_rstart = 1'b0;
        m_wstart = 1'b0;
        next_cycle();
    endtask

    //////////////////// tests
    task automatic check_reset_state();
        check_bit("datadir after reset", datadir, 1'b1);
        check_data("cd_out after reset", cd_out, 8'hFF);
        check_msel("msel_n after reset", msel_n, `MSEL_NONE);
        check_cmd_bits();
    endtask

    task automatic check_mux_sequence();
        logic [2:0] order [4];
        logic [2:0] last;
        int         idx;
        int         seen;
        order = '{`MSEL_ADDR_LO, `MSEL_ADDR_HI, `MSEL_CTRL, `MSEL_NONE};
        last  = msel_n;
        idx   = 0;
        seen  = 0;
        repeat (28) begin
            next_cycle();
            if (msel_n != last) begin
                check_msel("msel_n order", msel_n, order[idx]);
                idx  = (idx + 1) % 4;
                seen++;
                last = msel_n;
            end
        end
        if (seen < 12) begin
            $display("msel_n stopped stepping through the mux groups");
            abort_run();
        end
    endtask

    task automatic test_enable_gating();
        msx_addr_t a;
        msx_data_t v1;
        a  = `SDC_SDATA + {7'b0, 9'($urandom)};
        v1 = 8'($urandom);
        host_read_check("closed sector read", a);
        host_read_check("closed enable read", `SDC_ENABLE);
        host_read_check("closed status read", `SDC_STATUS);
        host_write(a, ~v1);                 // dropped while closed
        host_write(`SDC_ENABLE, 8'h01);
        host_read_check("enable read", `SDC_ENABLE);
        host_write(a, v1);
        host_write(`SDC_ENABLE, 8'h00);
        host_write(a, ~v1);
        host_read_check("closed sector read", a);
        host_write(`SDC_ENABLE, 8'h01);
        host_read_check("sector read after closed write", a);
    endtask

    task automatic test_sector_area();
        msx_addr_t a;
        msx_data_t rd;
        logic      dir;
        for (int i = 0; i < N_RANDOM; i++) begin
            if (known_q.size() == 0 || ($urandom % 2) == 0) begin
                a = `SDC_SDATA + {7'b0, 9'($urandom)};
                host_write(a, 8'($urandom));
            end else begin
                a = known_q[$urandom % known_q.size()];
                host_read_check("sector read", a);
            end
        end
        repeat (4) begin
            a = 16'($urandom);
            if (a >= `SDC_SDATA && a <= `SDC_END)
                a[15] = 1'b1;               // push it out of the window
            host_read_check("read outside window", a);
        end
        // sltsl_n high so nothing may respond
        a = known_q[0];
        host_access(a, 1'b0, 1'b0, 8'h00, rd, dir);
        check_bit("datadir outside slot", dir, 1'b1);
        host_access(a, 1'b1, 1'b0, ~m_mem[a[`SECTOR_AW-1:0]], rd, dir);
        host_read_check("sector after write outside slot", a);
    endtask

    task automatic test_registers();
        sector_t s;
        s = $urandom;
        for (int i = 0; i < 4; i++)
            host_write(`SDC_SADDR + 16'(i), s[8*i +: 8]);
        check_sector("sd_sector", sd_sector, m_sector);
        repeat (2) begin
            sd_busy          = 1'($urandom);
            sd_crc_error     = 1'($urandom);
            sd_timeout_error = 1'($urandom);
            sd_card_type     = 2'($urandom);
            sd_c_size        = 22'($urandom);
            host_read_check("status", `SDC_STATUS);
            host_read_check("card type", `SDC_CTYPE);
            host_read_check("size byte 0", `SDC_C_SIZE);
            host_read_check("size byte 1", `SDC_C_SIZE + 16'd1);
            host_read_check("size byte 2", `SDC_C_SIZE + 16'd2);
        end
        host_read_check("unused register", 16'h7E0B + 16'(4'($urandom)));
        host_write(`SDC_CMD, 8'h01);
        check_cmd_bits();
        host_write(`SDC_CMD, 8'h02);        // rstart is sticky and stays
        check_cmd_bits();
        done_pulse();
        check_cmd_bits();
        host_write(`SDC_CMD, 8'h80);
        check_cmd_bits();
    endtask

    task automatic test_card_port();
        msx_addr_t a;
        int        n;
        host_write(`SDC_CMD, 8'h01);
        check_cmd_bits();
        for (int i = 0; i < N_CARD; i++)
            card_write(9'($urandom), 8'($urandom));
        done_pulse();
        n = known_q.size();
        a = known_q[n - 1];
        card_write(a[`SECTOR_AW-1:0], ~m_mem[a[`SECTOR_AW-1:0]]);  // dropped without a read command
        for (int i = 0; i < N_CARD; i++) begin
            a = known_q[n - 1 - i];
            host_read_check("card filled byte", a);
        end
        host_write(`SDC_CMD, 8'h02);
        check_cmd_bits();
        for (int i = 0; i < N_CARD; i++) begin
            a = known_q[$urandom % known_q.size()];
            card_read_check(a[`SECTOR_AW-1:0]);
        end
        done_pulse();
        check_cmd_bits();
    endtask

    initial begin
        void'($urandom(32'hc79886bf));
        ram_enabled_w    = 1'b0;
        rd_n             = 1'b1;
        wr_n             = 1'b1;
        sltsl_n          = 1'b1;
        cd_in            = 8'hFF;
        sd_busy          = 1'b0;
        sd_done          = 1'b0;
        sd_crc_error     = 1'b0;
        sd_timeout_error = 1'b0;
        sd_card_type     = '0;
        sd_c_size        = '0;
        sd_outen         = 1'b0;
        sd_outaddr       = '0;
        sd_outbyte       = 8'h00;
        host_a           = 16'h0000;
        ctl_merq_n       = 1'b1;
        ctl_iorq_n       = 1'b1;
        ctl_m1_n         = 1'b1;
        m_enabled        = 1'b0;
        m_sector         = '0;
        m_rstart         = 1'b0;
        m_wstart         = 1'b0;
        m_init           = 1'b0;
        repeat (16) @(posedge clk108_w);
        #2;
        ram_enabled_w = 1'b1;
        check_reset_state();
        check_mux_sequence();
        test_enable_gating();
        test_sector_area();
        test_registers();
        test_card_port();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== wb_if.sv ====
`timescale 1ns/100ps

interface wb_if
    import msx_cart_pkg::*;
();

    logic      cyc;
    logic      stb;
    logic      we;
    wb_adr_t   adr;
    msx_data_t dat_w;   // master to slave
    msx_data_t dat_r;   // slave to master
    logic      ack;     // single cycle

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface
